// ==== build.f ====
+incdir+include
hdl/datapath_pkg.sv
hdl/bus_encoder.sv
hdl/bus_mux.sv
hdl/register_bank.sv
hdl/alu.sv
hdl/bus_datapath.sv
dv/clock_gen.sv
dv/tb_bus_datapath.sv

// ==== dv/bus_datapath_testdata.txt ====
// src_out gpr_in strobes(hi lo pc mdr ir y z mdr_read) alu_op mem_data in_port check expected
// A=f0f01234 B=0f0f0f05 C=fffffffd; a line starting with ffffffff ends the test
000000 0000 00 0 00000000 00000000 1 00000000
000001 0000 00 0 00000000 00000000 1 00000000
000002 0000 00 0 00000000 00000000 1 00000000
000004 0000 00 0 00000000 00000000 1 00000000
000008 0000 00 0 00000000 00000000 1 00000000
000010 0000 00 0 00000000 00000000 1 00000000
000020 0000 00 0 00000000 00000000 1 00000000
000040 0000 00 0 00000000 00000000 1 00000000
000080 0000 00 0 00000000 00000000 1 00000000
000100 0000 00 0 00000000 00000000 1 00000000
000200 0000 00 0 00000000 00000000 1 00000000
000400 0000 00 0 00000000 00000000 1 00000000
000800 0000 00 0 00000000 00000000 1 00000000
001000 0000 00 0 00000000 00000000 1 00000000
002000 0000 00 0 00000000 00000000 1 00000000
004000 0000 00 0 00000000 00000000 1 00000000
008000 0000 00 0 00000000 00000000 1 00000000
010000 0000 00 0 00000000 00000000 1 00000000
020000 0000 00 0 00000000 00000000 1 00000000
040000 0000 00 0 00000000 00000000 1 00000000
080000 0000 00 0 00000000 00000000 1 00000000
100000 0000 00 0 00000000 00000000 1 00000000
// MDR still reads zero here and takes A from memory
200000 0000 11 0 f0f01234 00000000 1 00000000
400000 0000 00 0 00000000 00000000 1 00000000
800000 0000 00 0 00000000 00000000 1 00000000
200000 00ff 11 0 0f0f0f05 00000000 1 f0f01234
200000 ff00 11 0 fffffffd 00000000 1 0f0f0f05
200000 0000 40 0 00000000 00000000 1 fffffffd
020000 0000 20 0 00000000 00000000 1 fffffffd
008000 0000 80 0 00000000 00000000 1 0f0f0f05
// ADD, Y from R0, bus from R8
000001 0000 04 0 00000000 00000000 1 f0f01234
000100 0000 02 0 00000000 00000000 1 0f0f0f05
080000 0000 00 0 00000000 00000000 1 ffff2139
040000 0000 00 0 00000000 00000000 1 ffffffff
000002 0000 04 0 00000000 00000000 1 f0f01234
000200 0000 02 1 00000000 00000000 1 0f0f0f05
080000 0000 00 0 00000000 00000000 1 e1e1032f
000004 0000 04 0 00000000 00000000 1 f0f01234
000400 0000 02 2 00000000 00000000 1 0f0f0f05
080000 0000 00 0 00000000 00000000 1 00000204
040000 0000 00 0 00000000 00000000 1 00000000
000008 0000 04 0 00000000 00000000 1 f0f01234
000800 0000 02 3 00000000 00000000 1 0f0f0f05
080000 0000 00 0 00000000 00000000 1 ffff1f35
// Shifts by 5
000010 0000 04 0 00000000 00000000 1 f0f01234
001000 0000 02 4 00000000 00000000 1 0f0f0f05
080000 0000 00 0 00000000 00000000 1 1e024680
000020 0000 04 0 00000000 00000000 1 f0f01234
002000 0000 02 5 00000000 00000000 1 0f0f0f05
080000 0000 00 0 00000000 00000000 1 07878091
000040 0000 02 6 00000000 00000000 1 f0f01234
080000 0000 00 0 00000000 00000000 1 0f0fedcc
000080 0000 02 7 00000000 00000000 1 f0f01234
080000 0000 00 0 00000000 00000000 1 0f0fedcb
// MUL, B from R14 times C from PC
004000 0000 04 0 00000000 00000000 1 0f0f0f05
100000 0000 02 8 00000000 00000000 1 fffffffd
080000 0000 00 0 00000000 00000000 1 d2d2d2f1
040000 0000 00 0 00000000 00000000 1 ffffffff
010000 0000 08 0 00000000 00000000 1 0f0f0f05
800000 0000 00 0 00000000 00000000 1 ffff0f05
400000 0000 00 0 00000000 13579bdf 1 00000000
400000 0000 00 0 00000000 13579bdf 1 13579bdf
ffffffff

// ==== dv/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic arst_n
);

    // 10 ns period.
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held low for the first 10 cycles.
    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// ==== dv/tb_bus_datapath.sv ====
`timescale 1ns/1ps
`include "datapath_defs.svh"

module tb_bus_datapath;

    // Eight words per step in the data file.
    localparam int WORDS     = 8;
    localparam int MAX_STEPS = 128;

    logic                   clk;
    logic                   arst_n;
    logic [`NUM_SRC-1:0]    src_out;
    logic [`NUM_GPR-1:0]    gpr_in;
    logic                   hi_in;
    logic                   lo_in;
    logic                   pc_in;
    logic                   mdr_in;
    logic                   ir_in;
    logic                   y_in;
    logic                   z_in;
    logic                   mdr_read;
    datapath_pkg::alu_op_e  alu_op;
    logic [`DATA_WIDTH-1:0] mem_data;
    logic [`DATA_WIDTH-1:0] in_port;
    logic [`DATA_WIDTH-1:0] bus_value;

    logic [31:0] test_vec [WORDS*MAX_STEPS];
    int          n_steps;
    int          cur_step;
    int          error_count;
    int          check_count;
    logic        steps_ready;

    clock_gen u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    bus_datapath DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .src_out   (src_out),
        .gpr_in    (gpr_in),
        .hi_in     (hi_in),
        .lo_in     (lo_in),
        .pc_in     (pc_in),
        .mdr_in    (mdr_in),
        .ir_in     (ir_in),
        .y_in      (y_in),
        .z_in      (z_in),
        .mdr_read  (mdr_read),
        .alu_op    (alu_op),
        .mem_data  (mem_data),
        .in_port   (in_port),
        .bus_value (bus_value)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error %s: expected %08h, got %08h at step %0d",
                     name, expected, actual, cur_step);
        end
    endtask

    // The strobe word holds hi lo pc mdr ir y z mdr_read from the msb down.
    task automatic apply_step(input int idx);
        int base;
        base = idx * WORDS;
        src_out  <= test_vec[base][`NUM_SRC-1:0];
        gpr_in   <= test_vec[base+1][`NUM_GPR-1:0];
        hi_in    <= test_vec[base+2][7];
        lo_in    <= test_vec[base+2][6];
        pc_in    <= test_vec[base+2][5];
        mdr_in   <= test_vec[base+2][4];
        ir_in    <= test_vec[base+2][3];
        y_in     <= test_vec[base+2][2];
        z_in     <= test_vec[base+2][1];
        mdr_read <= test_vec[base+2][0];
        alu_op   <= datapath_pkg::alu_op_e'(test_vec[base+3][3:0]);
        mem_data <= test_vec[base+4];
        in_port  <= test_vec[base+5];
    endtask

    initial begin
        src_out     = '0;
        gpr_in      = '0;
        hi_in       = 1'b0;
        lo_in       = 1'b0;
        pc_in       = 1'b0;
        mdr_in      = 1'b0;
        ir_in       = 1'b0;
        y_in        = 1'b0;
        z_in        = 1'b0;
        mdr_read    = 1'b0;
        alu_op      = datapath_pkg::ALU_ADD;
        mem_data    = '0;
        in_port     = '0;
        n_steps     = 0;
        cur_step    = 0;
        error_count = 0;
        check_count = 0;
        steps_ready = 1'b0;

        $readmemh("dv/bus_datapath_testdata.txt", test_vec);
        while (n_steps < MAX_STEPS && test_vec[n_steps*WORDS] != 32'hffff_ffff) begin
            n_steps++;
        end
        if (n_steps == MAX_STEPS) begin
            $display("The test data has no end marker, so no steps were run");
            error_count++;
            n_steps = 0;
        end
        steps_ready = 1'b1;

        wait (arst_n === 1'b1);
        for (int i = 0; i < n_steps; i++) begin
            @(posedge clk);
            cur_step = i;
            apply_step(i);
            // Mid-cycle the bus has settled.
            @(negedge clk);
            if (test_vec[i*WORDS+6][0]) begin
                check_value("bus_value", bus_value, test_vec[i*WORDS+7]);
            end
        end

        if (check_count == 0) begin
            $display("No step of the test data was checked against the bus");
            error_count++;
        end

        @(posedge clk);
        $display("Steps: %0d, checks: %0d, errors: %0d", n_steps, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog covering reset, every step and some margin.
    initial begin
        wait (steps_ready === 1'b1);
        #((n_steps + 20) * 10);
        $display("Timeout: the run did not finish within %0d cycles", n_steps + 20);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`include "datapath_defs.svh"

module alu (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`DATA_WIDTH-1:0]  bus,
    input  logic                    y_in,
    input  logic                    z_in,
    input  datapath_pkg::alu_op_e   alu_op,
    output logic [`DATA_WIDTH-1:0]  zhi,
    output logic [`DATA_WIDTH-1:0]  zlo
);

    logic [`DATA_WIDTH-1:0]     y;
    logic [2*`DATA_WIDTH-1:0]   product;
    logic [2*`DATA_WIDTH-1:0]   result;
    logic [`DATA_WIDTH-1:0]     low_res;
    logic [4:0]                 shamt;

    // First operand register.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            y <= '0;
        end else if (y_in) begin
            y <= bus;
        end
    end

    // Signed 32x32 multiply, full 64-bit product.
    assign product = $signed(y) * $signed(bus);
    assign shamt   = bus[4:0];

    always_comb begin
        case (alu_op)
            datapath_pkg::ALU_ADD: low_res = y + bus;
            datapath_pkg::ALU_SUB: low_res = y - bus;
            datapath_pkg::ALU_AND: low_res = y & bus;
            datapath_pkg::ALU_OR:  low_res = y | bus;
            datapath_pkg::ALU_SHL: low_res = y << shamt;
            datapath_pkg::ALU_SHR: low_res = y >> shamt;
            datapath_pkg::ALU_NEG: low_res = -bus;
            datapath_pkg::ALU_NOT: low_res = ~bus;
            default:               low_res = '0;
        endcase

        // MUL fills both halves, everything else sign-fills ZHI.
        if (alu_op == datapath_pkg::ALU_MUL) begin
            result = product;
        end else begin
            result = {{`DATA_WIDTH{low_res[`DATA_WIDTH-1]}}, low_res};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            zhi <= '0;
            zlo <= '0;
        end else if (z_in) begin
            zhi <= result[2*`DATA_WIDTH-1:`DATA_WIDTH];
            zlo <= result[`DATA_WIDTH-1:0];
        end
    end

    // Z must never capture the result of an undefined opcode.
    a_op_defined: assert property (
        @(posedge clk) disable iff (!arst_n)
        z_in |-> ($unsigned(alu_op) <= $unsigned(datapath_pkg::ALU_MUL))
    ) else $error("alu: undefined opcode %0d with z_in", alu_op);

endmodule

// ==== hdl/bus_datapath.sv ====
`timescale 1ns/1ps
`include "datapath_defs.svh"

module bus_datapath (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`NUM_SRC-1:0]     src_out,
    input  logic [`NUM_GPR-1:0]     gpr_in,
    input  logic                    hi_in,
    input  logic                    lo_in,
    input  logic                    pc_in,
    input  logic                    mdr_in,
    input  logic                    ir_in,
    input  logic                    y_in,
    input  logic                    z_in,
    input  logic                    mdr_read,
    input  datapath_pkg::alu_op_e   alu_op,
    input  logic [`DATA_WIDTH-1:0]  mem_data,
    input  logic [`DATA_WIDTH-1:0]  in_port,
    output logic [`DATA_WIDTH-1:0]  bus_value
);

    datapath_pkg::bus_src_e  src_sel;
    logic [`DATA_WIDTH-1:0]  bus;
    logic [`DATA_WIDTH-1:0]  gpr [`NUM_GPR];
    logic [`DATA_WIDTH-1:0]  hi;
    logic [`DATA_WIDTH-1:0]  lo;
    logic [`DATA_WIDTH-1:0]  pc;
    logic [`DATA_WIDTH-1:0]  mdr;
    logic [`DATA_WIDTH-1:0]  inport;
    logic [`DATA_WIDTH-1:0]  c_sign_ext;
    logic [`DATA_WIDTH-1:0]  zhi;
    logic [`DATA_WIDTH-1:0]  zlo;

    bus_encoder u_encoder (
        .clk     (clk),
        .arst_n  (arst_n),
        .src_out (src_out),
        .src_sel (src_sel)
    );

    bus_mux u_mux (
        .src_sel    (src_sel),
        .gpr        (gpr),
        .hi         (hi),
        .lo         (lo),
        .zhi        (zhi),
        .zlo        (zlo),
        .pc         (pc),
        .mdr        (mdr),
        .inport     (inport),
        .c_sign_ext (c_sign_ext),
        .bus        (bus)
    );

    register_bank u_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .bus        (bus),
        .gpr_in     (gpr_in),
        .hi_in      (hi_in),
        .lo_in      (lo_in),
        .pc_in      (pc_in),
        .mdr_in     (mdr_in),
        .mdr_read   (mdr_read),
        .ir_in      (ir_in),
        .mem_data   (mem_data),
        .in_port    (in_port),
        .gpr        (gpr),
        .hi         (hi),
        .lo         (lo),
        .pc         (pc),
        .mdr        (mdr),
        .inport     (inport),
        .c_sign_ext (c_sign_ext)
    );

    alu u_alu (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (bus),
        .y_in   (y_in),
        .z_in   (z_in),
        .alu_op (alu_op),
        .zhi    (zhi),
        .zlo    (zlo)
    );

    // The bus is visible to the controller in the same cycle.
    assign bus_value = bus;

endmodule

// ==== hdl/bus_encoder.sv ====
`timescale 1ns/1ps
`include "datapath_defs.svh"

module bus_encoder (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`NUM_SRC-1:0]    src_out,
    output datapath_pkg::bus_src_e src_sel
);

    // Priority scan, the highest set strobe wins.
    // With a legal one-hot input the order does not matter.
    always_comb begin
        src_sel = datapath_pkg::SRC_NONE;
        for (int i = 0; i < `NUM_SRC; i++) begin
            if (src_out[i]) begin
                src_sel = datapath_pkg::bus_src_e'(`SEL_WIDTH'(i));
            end
        end
    end

    // Two drivers on the shared bus in the same cycle is a controller bug.
    a_src_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(src_out)
    ) else $error("bus_encoder: more than one out strobe high (%h)", src_out);

endmodule

// ==== hdl/bus_mux.sv ====
`timescale 1ns/1ps
`include "datapath_defs.svh"

module bus_mux (
    input  datapath_pkg::bus_src_e  src_sel,
    input  logic [`DATA_WIDTH-1:0]  gpr [`NUM_GPR],
    input  logic [`DATA_WIDTH-1:0]  hi,
    input  logic [`DATA_WIDTH-1:0]  lo,
    input  logic [`DATA_WIDTH-1:0]  zhi,
    input  logic [`DATA_WIDTH-1:0]  zlo,
    input  logic [`DATA_WIDTH-1:0]  pc,
    input  logic [`DATA_WIDTH-1:0]  mdr,
    input  logic [`DATA_WIDTH-1:0]  inport,
    input  logic [`DATA_WIDTH-1:0]  c_sign_ext,
    output logic [`DATA_WIDTH-1:0]  bus
);

    // Pure selector, no state.
    always_comb begin
        case (src_sel)
            datapath_pkg::SRC_R0:     bus = gpr[0];
            datapath_pkg::SRC_R1:     bus = gpr[1];
            datapath_pkg::SRC_R2:     bus = gpr[2];
            datapath_pkg::SRC_R3:     bus = gpr[3];
            datapath_pkg::SRC_R4:     bus = gpr[4];
            datapath_pkg::SRC_R5:     bus = gpr[5];
            datapath_pkg::SRC_R6:     bus = gpr[6];
            datapath_pkg::SRC_R7:     bus = gpr[7];
            datapath_pkg::SRC_R8:     bus = gpr[8];
            datapath_pkg::SRC_R9:     bus = gpr[9];
            datapath_pkg::SRC_R10:    bus = gpr[10];
            datapath_pkg::SRC_R11:    bus = gpr[11];
            datapath_pkg::SRC_R12:    bus = gpr[12];
            datapath_pkg::SRC_R13:    bus = gpr[13];
            datapath_pkg::SRC_R14:    bus = gpr[14];
            datapath_pkg::SRC_R15:    bus = gpr[15];
            datapath_pkg::SRC_HI:     bus = hi;
            datapath_pkg::SRC_LO:     bus = lo;
            datapath_pkg::SRC_ZHI:    bus = zhi;
            datapath_pkg::SRC_ZLO:    bus = zlo;
            datapath_pkg::SRC_PC:     bus = pc;
            datapath_pkg::SRC_MDR:    bus = mdr;
            datapath_pkg::SRC_INPORT: bus = inport;
            datapath_pkg::SRC_CSIGN:  bus = c_sign_ext;
            // Nothing driving, the bus floats to zero.
            default:                  bus = '0;
        endcase
    end

endmodule

// ==== hdl/datapath_pkg.sv ====
`include "datapath_defs.svh"

package datapath_pkg;

    // Source numbers match the bit positions of the out-strobe vector.
    typedef enum logic [`SEL_WIDTH-1:0] {
        SRC_R0  = 5'd0,  SRC_R1  = 5'd1,  SRC_R2  = 5'd2,  SRC_R3  = 5'd3,
        SRC_R4  = 5'd4,  SRC_R5  = 5'd5,  SRC_R6  = 5'd6,  SRC_R7  = 5'd7,
        SRC_R8  = 5'd8,  SRC_R9  = 5'd9,  SRC_R10 = 5'd10, SRC_R11 = 5'd11,
        SRC_R12 = 5'd12, SRC_R13 = 5'd13, SRC_R14 = 5'd14, SRC_R15 = 5'd15,
        SRC_HI     = 5'd16,
        SRC_LO     = 5'd17,
        SRC_ZHI    = 5'd18,
        SRC_ZLO    = 5'd19,
        SRC_PC     = 5'd20,
        SRC_MDR    = 5'd21,
        SRC_INPORT = 5'd22,
        SRC_CSIGN  = 5'd23,
        SRC_NONE   = 5'd31
    } bus_src_e;

    // Shifts use the bus value modulo 32, SHR is logical.
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0, ALU_SUB = 4'd1, ALU_AND = 4'd2,
        ALU_OR  = 4'd3, ALU_SHL = 4'd4, ALU_SHR = 4'd5,
        ALU_NEG = 4'd6, ALU_NOT = 4'd7, ALU_MUL = 4'd8
    } alu_op_e;

endpackage

// ==== hdl/register_bank.sv ====
`timescale 1ns/1ps
`include "datapath_defs.svh"

module register_bank (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`DATA_WIDTH-1:0] bus,
    input  logic [`NUM_GPR-1:0]    gpr_in,
    input  logic                   hi_in,
    input  logic                   lo_in,
    input  logic                   pc_in,
    input  logic                   mdr_in,
    input  logic                   mdr_read,
    input  logic                   ir_in,
    input  logic [`DATA_WIDTH-1:0] mem_data,
    input  logic [`DATA_WIDTH-1:0] in_port,
    output logic [`DATA_WIDTH-1:0] gpr [`NUM_GPR],
    output logic [`DATA_WIDTH-1:0] hi,
    output logic [`DATA_WIDTH-1:0] lo,
    output logic [`DATA_WIDTH-1:0] pc,
    output logic [`DATA_WIDTH-1:0] mdr,
    output logic [`DATA_WIDTH-1:0] inport,
    output logic [`DATA_WIDTH-1:0] c_sign_ext
);

    logic [`DATA_WIDTH-1:0] ir;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `NUM_GPR; i++) begin
                gpr[i] <= '0;
            end
            hi     <= '0;
            lo     <= '0;
            pc     <= '0;
            mdr    <= '0;
            ir     <= '0;
            inport <= '0;
        end else begin
            for (int i = 0; i < `NUM_GPR; i++) begin
                if (gpr_in[i]) gpr[i] <= bus;
            end
            if (hi_in) hi <= bus;
            if (lo_in) lo <= bus;
            if (pc_in) pc <= bus;
            if (ir_in) ir <= bus;
            // MDR takes memory data on a read, the bus otherwise.
            if (mdr_in) mdr <= mdr_read ? mem_data : bus;
            // Input port is sampled every cycle.
            inport <= in_port;
        end
    end

    assign c_sign_ext = {{(`DATA_WIDTH - `IMM_WIDTH){ir[`IMM_WIDTH-1]}}, ir[`IMM_WIDTH-1:0]};

    // A memory read without the MDR load strobe would be lost.
    a_mdr_read: assert property (
        @(posedge clk) disable iff (!arst_n)
        mdr_read |-> mdr_in
    ) else $error("register_bank: mdr_read high without mdr_in");

endmodule

// ==== include/datapath_defs.svh ====
`ifndef DATAPATH_DEFS_SVH
`define DATAPATH_DEFS_SVH

// Width of the shared bus and of every register.
`define DATA_WIDTH 32

// General purpose registers R0 to R15.
`define NUM_GPR 16

// Bus sources, one out strobe per source.
`define NUM_SRC 24

// Encoded source number, wide enough for 32 entries.
`define SEL_WIDTH 5

// Constant field of the instruction register, bits 18 down to 0.
`define IMM_WIDTH 19

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the bus datapath testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f build.f \
    --top-module tb_bus_datapath -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
